// ==== include/xbar_consts.svh ====
`ifndef XBAR_CONSTS_SVH
`define XBAR_CONSTS_SVH

// master side id width
`define XBAR_ID_W     4

// index of the issuing master, prepended to the id
`define XBAR_MIDX_W   1

// slave side id holds master index plus master id
`define XBAR_SID_W    5

`define XBAR_ADDR_W   32
`define XBAR_LEN_W    4
`define XBAR_BURST_W  2
`define XBAR_RESP_W   2

// one bit picks one of the two slaves
`define XBAR_SEL_W    1

`endif

// ==== design/xbar_pkg.sv ====
`include "xbar_consts.svh"

package xbar_pkg;

    typedef logic [`XBAR_ID_W-1:0]    mid_t;
    typedef logic [`XBAR_ADDR_W-1:0]  addr_t;
    typedef logic [`XBAR_LEN_W-1:0]   len_t;
    typedef logic [`XBAR_BURST_W-1:0] burst_t;
    typedef logic [`XBAR_RESP_W-1:0]  resp_t;

    // master index sits above the master's own id
    typedef struct packed {
        logic [`XBAR_MIDX_W-1:0] midx;
        mid_t                    mid;
    } tag_id_t;

    // slaves only ever see raw while the crossbar reads the tag
    typedef union packed {
        logic [`XBAR_SID_W-1:0] raw;
        tag_id_t                tag;
    } sid_t;

endpackage

// ==== design/aw_req_if.sv ====
interface aw_req_if
    import xbar_pkg::*;
();

    logic   valid;
    logic   ready;
    sid_t   sid;
    addr_t  addr;
    len_t   len;
    burst_t burst;

    modport decoder (
        output valid,
        output sid,
        output addr,
        output len,
        output burst,
        input  ready
    );

    modport arbiter (
        input  valid,
        input  sid,
        input  addr,
        input  len,
        input  burst,
        output ready
    );

endinterface

// ==== design/aw_request_decode.sv ====
`include "xbar_consts.svh"

module aw_request_decode
    import xbar_pkg::*;
#(
    parameter logic [`XBAR_MIDX_W-1:0] midx = '0
) (
    input  mid_t                   m_awid,
    input  addr_t                  m_awaddr,
    input  len_t                   m_awlen,
    input  burst_t                 m_awburst,
    input  logic                   m_awvalid,
    output logic                   m_awready,
    input  logic [`XBAR_SEL_W-1:0] route_sel,
    input  logic                   route_en,
    aw_req_if.decoder              lane0,
    aw_req_if.decoder              lane1
);

    sid_t tagged_sid;
    logic to_s0;
    logic to_s1;

    always_comb begin
        tagged_sid.tag.midx = midx;
        tagged_sid.tag.mid  = m_awid;
    end

    assign to_s0 = route_en && (route_sel == '0);
    assign to_s1 = route_en && (route_sel != '0);

    // payload goes out on both lanes but valid only on the chosen one
    assign lane0.sid   = tagged_sid;
    assign lane0.addr  = m_awaddr;
    assign lane0.len   = m_awlen;
    assign lane0.burst = m_awburst;
    assign lane0.valid = m_awvalid && to_s0;

    assign lane1.sid   = tagged_sid;
    assign lane1.addr  = m_awaddr;
    assign lane1.len   = m_awlen;
    assign lane1.burst = m_awburst;
    assign lane1.valid = m_awvalid && to_s1;

    assign m_awready = to_s0 ? lane0.ready :
                       to_s1 ? lane1.ready : 1'b0;

endmodule

// ==== design/aw_slave_arbiter.sv ====
`include "xbar_consts.svh"

module aw_slave_arbiter
    import xbar_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    aw_req_if.arbiter              from_m0,
    aw_req_if.arbiter              from_m1,
    output logic [`XBAR_SID_W-1:0] s_awid,
    output addr_t                  s_awaddr,
    output len_t                   s_awlen,
    output burst_t                 s_awburst,
    output logic                   s_awvalid,
    input  logic                   s_awready
);

    // grant 0 means master 0
    logic grant;
    logic grant_q;
    logic locked;

    // master 0 first unless a stalled transfer holds the port
    always_comb begin
        if (locked) begin
            grant = grant_q;
        end else begin
            grant = !from_m0.valid;
        end
    end

    always_comb begin
        if (grant) begin
            s_awid    = from_m1.sid.raw;
            s_awaddr  = from_m1.addr;
            s_awlen   = from_m1.len;
            s_awburst = from_m1.burst;
            s_awvalid = from_m1.valid;
        end else begin
            s_awid    = from_m0.sid.raw;
            s_awaddr  = from_m0.addr;
            s_awlen   = from_m0.len;
            s_awburst = from_m0.burst;
            s_awvalid = from_m0.valid;
        end
    end

    assign from_m0.ready = !grant && s_awready;
    assign from_m1.ready = grant && s_awready;

    // lock while valid waits and release on the handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked  <= 1'b0;
            grant_q <= 1'b0;
        end else begin
            locked  <= s_awvalid && !s_awready;
            grant_q <= grant;
        end
    end

    // holds only if the lock and the masters both obey the handshake
    a_aw_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        s_awvalid && !s_awready |=> s_awvalid && $stable(s_awaddr)
    ) else $error("awvalid or awaddr changed before awready");

endmodule

// ==== design/b_response_router.sv ====
`include "xbar_consts.svh"

module b_response_router
    import xbar_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  sid_t  s0_bid,
    input  sid_t  s1_bid,
    input  resp_t s0_bresp,
    input  resp_t s1_bresp,
    input  logic  s0_bvalid,
    input  logic  s1_bvalid,
    output logic  s0_bready,
    output logic  s1_bready,
    output mid_t  m0_bid,
    output mid_t  m1_bid,
    output resp_t m0_bresp,
    output resp_t m1_bresp,
    output logic  m0_bvalid,
    output logic  m1_bvalid,
    input  logic  m0_bready,
    input  logic  m1_bready
);

    sid_t       bid   [2];
    resp_t      bresp [2];
    logic [1:0] bvalid;
    logic [1:0] m_ready;
    // slave s holds a response for master m in hit[m][s]
    logic [1:0] hit   [2];
    logic [1:0] pick;
    logic [1:0] pick_q;
    logic [1:0] locked;
    logic [1:0] fwd_valid;
    mid_t       fwd_id   [2];
    resp_t      fwd_resp [2];
    logic [1:0] s_ready;

    assign bid[0]   = s0_bid;
    assign bid[1]   = s1_bid;
    assign bresp[0] = s0_bresp;
    assign bresp[1] = s1_bresp;
    assign bvalid   = {s1_bvalid, s0_bvalid};
    assign m_ready  = {m1_bready, m0_bready};

    always_comb begin
        for (int m = 0; m < 2; m++) begin
            for (int s = 0; s < 2; s++) begin
                hit[m][s] = bvalid[s] && (bid[s].tag.midx == `XBAR_MIDX_W'(m));
            end
            pick[m]      = locked[m] ? pick_q[m] : !hit[m][0];
            fwd_valid[m] = hit[m][pick[m]];
            // strip the master index on the way back
            fwd_id[m]    = bid[pick[m]].tag.mid;
            fwd_resp[m]  = bresp[pick[m]];
        end
        for (int s = 0; s < 2; s++) begin
            s_ready[s] = 1'b0;
            for (int m = 0; m < 2; m++) begin
                if (hit[m][s] && (pick[m] == 1'(s))) begin
                    s_ready[s] = m_ready[m];
                end
            end
        end
    end

    assign m0_bid    = fwd_id[0];
    assign m1_bid    = fwd_id[1];
    assign m0_bresp  = fwd_resp[0];
    assign m1_bresp  = fwd_resp[1];
    assign m0_bvalid = fwd_valid[0];
    assign m1_bvalid = fwd_valid[1];
    assign s0_bready = s_ready[0];
    assign s1_bready = s_ready[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked <= '0;
            pick_q <= '0;
        end else begin
            locked <= fwd_valid & ~m_ready;
            pick_q <= pick;
        end
    end

    // a stalled response keeps its slave and its id
    a_m0_b_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        m0_bvalid && !m0_bready |=> m0_bvalid && $stable(m0_bid)
    ) else $error("m0 bvalid or bid changed before bready");

    a_m1_b_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        m1_bvalid && !m1_bready |=> m1_bvalid && $stable(m1_bid)
    ) else $error("m1 bvalid or bid changed before bready");

endmodule

// ==== design/axi_xbar_2x2.sv ====
`include "xbar_consts.svh"

module axi_xbar_2x2
    import xbar_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // master 0
    input  mid_t                   m0_awid,
    input  addr_t                  m0_awaddr,
    input  len_t                   m0_awlen,
    input  burst_t                 m0_awburst,
    input  logic                   m0_awvalid,
    output logic                   m0_awready,
    input  logic [`XBAR_SEL_W-1:0] m0_write_addr_sel,
    input  logic                   m0_write_addr_en,
    output mid_t                   m0_bid,
    output resp_t                  m0_bresp,
    output logic                   m0_bvalid,
    input  logic                   m0_bready,

    // master 1
    input  mid_t                   m1_awid,
    input  addr_t                  m1_awaddr,
    input  len_t                   m1_awlen,
    input  burst_t                 m1_awburst,
    input  logic                   m1_awvalid,
    output logic                   m1_awready,
    input  logic [`XBAR_SEL_W-1:0] m1_write_addr_sel,
    input  logic                   m1_write_addr_en,
    output mid_t                   m1_bid,
    output resp_t                  m1_bresp,
    output logic                   m1_bvalid,
    input  logic                   m1_bready,

    // slave 0
    output logic [`XBAR_SID_W-1:0] s0_awid,
    output addr_t                  s0_awaddr,
    output len_t                   s0_awlen,
    output burst_t                 s0_awburst,
    output logic                   s0_awvalid,
    input  logic                   s0_awready,
    input  logic [`XBAR_SID_W-1:0] s0_bid,
    input  resp_t                  s0_bresp,
    input  logic                   s0_bvalid,
    output logic                   s0_bready,

    // slave 1
    output logic [`XBAR_SID_W-1:0] s1_awid,
    output addr_t                  s1_awaddr,
    output len_t                   s1_awlen,
    output burst_t                 s1_awburst,
    output logic                   s1_awvalid,
    input  logic                   s1_awready,
    input  logic [`XBAR_SID_W-1:0] s1_bid,
    input  resp_t                  s1_bresp,
    input  logic                   s1_bvalid,
    output logic                   s1_bready
);

    // one lane per master and slave pair
    aw_req_if m0_to_s0 ();
    aw_req_if m0_to_s1 ();
    aw_req_if m1_to_s0 ();
    aw_req_if m1_to_s1 ();

    aw_request_decode #(
        .midx (`XBAR_MIDX_W'(0))
    ) u_dec_m0 (
        .m_awid    (m0_awid),
        .m_awaddr  (m0_awaddr),
        .m_awlen   (m0_awlen),
        .m_awburst (m0_awburst),
        .m_awvalid (m0_awvalid),
        .m_awready (m0_awready),
        .route_sel (m0_write_addr_sel),
        .route_en  (m0_write_addr_en),
        .lane0     (m0_to_s0.decoder),
        .lane1     (m0_to_s1.decoder)
    );

    aw_request_decode #(
        .midx (`XBAR_MIDX_W'(1))
    ) u_dec_m1 (
        .m_awid    (m1_awid),
        .m_awaddr  (m1_awaddr),
        .m_awlen   (m1_awlen),
        .m_awburst (m1_awburst),
        .m_awvalid (m1_awvalid),
        .m_awready (m1_awready),
        .route_sel (m1_write_addr_sel),
        .route_en  (m1_write_addr_en),
        .lane0     (m1_to_s0.decoder),
        .lane1     (m1_to_s1.decoder)
    );

    aw_slave_arbiter u_arb_s0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .from_m0   (m0_to_s0.arbiter),
        .from_m1   (m1_to_s0.arbiter),
        .s_awid    (s0_awid),
        .s_awaddr  (s0_awaddr),
        .s_awlen   (s0_awlen),
        .s_awburst (s0_awburst),
        .s_awvalid (s0_awvalid),
        .s_awready (s0_awready)
    );

    aw_slave_arbiter u_arb_s1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .from_m0   (m0_to_s1.arbiter),
        .from_m1   (m1_to_s1.arbiter),
        .s_awid    (s1_awid),
        .s_awaddr  (s1_awaddr),
        .s_awlen   (s1_awlen),
        .s_awburst (s1_awburst),
        .s_awvalid (s1_awvalid),
        .s_awready (s1_awready)
    );

    // responses find their way back through the id tag
    b_response_router u_b_router (
        .clk       (clk),
        .rst_n     (rst_n),
        .s0_bid    (s0_bid),
        .s1_bid    (s1_bid),
        .s0_bresp  (s0_bresp),
        .s1_bresp  (s1_bresp),
        .s0_bvalid (s0_bvalid),
        .s1_bvalid (s1_bvalid),
        .s0_bready (s0_bready),
        .s1_bready (s1_bready),
        .m0_bid    (m0_bid),
        .m1_bid    (m1_bid),
        .m0_bresp  (m0_bresp),
        .m1_bresp  (m1_bresp),
        .m0_bvalid (m0_bvalid),
        .m1_bvalid (m1_bvalid),
        .m0_bready (m0_bready),
        .m1_bready (m1_bready)
    );

endmodule

// ==== verif/tb_axi_xbar.sv ====
`include "xbar_consts.svh"

module tb_axi_xbar
    import xbar_pkg::*;
();

    localparam int PERIOD = 100;
    localparam logic [1:0] SRC_0 = 2'd0;
    localparam logic [1:0] SRC_1 = 2'd1;
    localparam logic [1:0] IDLE  = 2'd2;

    // bit 0 of each pair belongs to master 0 or slave 0
    typedef struct packed {
        logic [1:0] m_v;
        logic [1:0] m_en;
        logic [1:0] m_sel;
        logic [1:0] s_rdy;
        logic [1:0] exp_s0_src;
        logic [1:0] exp_s1_src;
        logic [1:0] exp_m_rdy;
        logic [1:0] s_bv;
        logic [1:0] s_tag;
        logic [1:0] m_brdy;
        logic [1:0] exp_m0_src;
        logic [1:0] exp_m1_src;
        logic [1:0] exp_s_brdy;
    } entry_t;

    logic                   clk;
    logic                   rst_n;
    mid_t                   m0_awid, m1_awid, m0_bid, m1_bid;
    addr_t                  m0_awaddr, m1_awaddr, s0_awaddr, s1_awaddr;
    len_t                   m0_awlen, m1_awlen, s0_awlen, s1_awlen;
    burst_t                 m0_awburst, m1_awburst, s0_awburst, s1_awburst;
    resp_t                  m0_bresp, m1_bresp, s0_bresp, s1_bresp;
    logic [`XBAR_SEL_W-1:0] m0_write_addr_sel, m1_write_addr_sel;
    logic [`XBAR_SID_W-1:0] s0_awid, s1_awid, s0_bid, s1_bid;
    logic                   m0_awvalid, m1_awvalid, m0_awready, m1_awready;
    logic                   m0_write_addr_en, m1_write_addr_en;
    logic                   s0_awvalid, s1_awvalid, s0_awready, s1_awready;
    logic                   m0_bvalid, m1_bvalid, m0_bready, m1_bready;
    logic                   s0_bvalid, s1_bvalid, s0_bready, s1_bready;

    mid_t        awid_v    [2];
    addr_t       awaddr_v  [2];
    len_t        awlen_v   [2];
    burst_t      awburst_v [2];
    mid_t        bmid_v    [2];
    resp_t       bresp_v   [2];
    entry_t      cur;
    entry_t      entries [$];
    logic [31:0] rand_state = 32'd24;
    int          errors = 0;
    int          checks = 0;
    bit          table_built = 1'b0;

    axi_xbar_2x2 uut (.*);

    assign m0_awid           = awid_v[0];
    assign m0_awaddr         = awaddr_v[0];
    assign m0_awlen          = awlen_v[0];
    assign m0_awburst        = awburst_v[0];
    assign m0_awvalid        = cur.m_v[0];
    assign m0_write_addr_en  = cur.m_en[0];
    assign m0_write_addr_sel = cur.m_sel[0];
    assign m0_bready         = cur.m_brdy[0];
    assign m1_awid           = awid_v[1];
    assign m1_awaddr         = awaddr_v[1];
    assign m1_awlen          = awlen_v[1];
    assign m1_awburst        = awburst_v[1];
    assign m1_awvalid        = cur.m_v[1];
    assign m1_write_addr_en  = cur.m_en[1];
    assign m1_write_addr_sel = cur.m_sel[1];
    assign m1_bready         = cur.m_brdy[1];
    assign s0_awready        = cur.s_rdy[0];
    assign s0_bid            = {cur.s_tag[0], bmid_v[0]};
    assign s0_bresp          = bresp_v[0];
    assign s0_bvalid         = cur.s_bv[0];
    assign s1_awready        = cur.s_rdy[1];
    assign s1_bid            = {cur.s_tag[1], bmid_v[1]};
    assign s1_bresp          = bresp_v[1];
    assign s1_bvalid         = cur.s_bv[1];

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (table_built);
        #(2 * entries.size() * PERIOD);
        $display("watchdog timeout, the table run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    task add_aw(input logic [1:0] m_v, m_en, m_sel, s_rdy, s0_src, s1_src, m_rdy);
        entries.push_back({m_v, m_en, m_sel, s_rdy, s0_src, s1_src, m_rdy,
                           6'b0, IDLE, IDLE, 2'b00});
    endtask

    task add_b(input logic [1:0] s_bv, s_tag, m_brdy, m0_src, m1_src, s_brdy);
        entries.push_back({8'b0, IDLE, IDLE, 2'b00, s_bv, s_tag, m_brdy, m0_src, m1_src, s_brdy});
    endtask

    task drive_entry(input entry_t e, input entry_t prev);
        logic [31:0] r;
        for (int i = 0; i < 2; i++) begin
            // stalled transfers keep their payload
            if (!(prev.m_v[i] && !prev.exp_m_rdy[i])) begin
                r = next_rand();
                awid_v[i]    = r[31:28];
                awlen_v[i]   = r[11:8];
                awburst_v[i] = r[5:4];
                awaddr_v[i]  = next_rand();
            end
            if (!(prev.s_bv[i] && !prev.exp_s_brdy[i])) begin
                r = next_rand();
                bmid_v[i]  = r[27:24];
                bresp_v[i] = r[19:18];
            end
        end
        cur = e;
    endtask

    task compare(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    task check_slave(input int s, input logic [1:0] src, input logic valid,
                     input logic [`XBAR_SID_W-1:0] id, input addr_t addr,
                     input len_t len, input burst_t burst);
        logic m;
        m = src[0];
        compare($sformatf("s%0d_awvalid", s), valid, src != IDLE);
        if (src != IDLE) begin
            // master index lands above the master's own id
            compare($sformatf("s%0d_awid", s), id, {m, awid_v[m]});
            compare($sformatf("s%0d_awaddr", s), addr, awaddr_v[m]);
            compare($sformatf("s%0d_awlen", s), len, awlen_v[m]);
            compare($sformatf("s%0d_awburst", s), burst, awburst_v[m]);
        end
    endtask

    task check_master_b(input int m, input logic [1:0] src, input logic valid,
                        input mid_t id, input resp_t resp);
        compare($sformatf("m%0d_bvalid", m), valid, src != IDLE);
        if (src != IDLE) begin
            compare($sformatf("m%0d_bid", m), id, bmid_v[src[0]]);
            compare($sformatf("m%0d_bresp", m), resp, bresp_v[src[0]]);
        end
    endtask

    task check_entry(input entry_t e);
        compare("m0_awready", m0_awready, e.exp_m_rdy[0]);
        compare("m1_awready", m1_awready, e.exp_m_rdy[1]);
        compare("s0_bready", s0_bready, e.exp_s_brdy[0]);
        compare("s1_bready", s1_bready, e.exp_s_brdy[1]);
        check_slave(0, e.exp_s0_src, s0_awvalid, s0_awid, s0_awaddr, s0_awlen, s0_awburst);
        check_slave(1, e.exp_s1_src, s1_awvalid, s1_awid, s1_awaddr, s1_awlen, s1_awburst);
        check_master_b(0, e.exp_m0_src, m0_bvalid, m0_bid, m0_bresp);
        check_master_b(1, e.exp_m1_src, m1_bvalid, m1_bid, m1_bresp);
    endtask

    initial begin
        entry_t prev;
        prev = '0;
        rst_n = 1'b0;
        drive_entry('0, '0);
        add_aw(2'b00, 2'b00, 2'b00, 2'b00, IDLE, IDLE, 2'b00);
        // single master, then route_en low
        add_aw(2'b01, 2'b01, 2'b00, 2'b01, SRC_0, IDLE, 2'b01);
        add_aw(2'b10, 2'b10, 2'b10, 2'b10, IDLE, SRC_1, 2'b10);
        add_aw(2'b01, 2'b01, 2'b01, 2'b10, IDLE, SRC_0, 2'b01);
        add_aw(2'b01, 2'b00, 2'b00, 2'b11, IDLE, IDLE, 2'b00);
        add_aw(2'b10, 2'b00, 2'b10, 2'b11, IDLE, IDLE, 2'b00);
        // contention and parallel paths
        add_aw(2'b11, 2'b11, 2'b00, 2'b01, SRC_0, IDLE, 2'b01);
        add_aw(2'b10, 2'b10, 2'b00, 2'b01, SRC_1, IDLE, 2'b10);
        add_aw(2'b11, 2'b11, 2'b01, 2'b11, SRC_1, SRC_0, 2'b11);
        add_aw(2'b11, 2'b11, 2'b10, 2'b11, SRC_0, SRC_1, 2'b11);
        add_aw(2'b11, 2'b11, 2'b11, 2'b10, IDLE, SRC_0, 2'b01);
        add_aw(2'b10, 2'b10, 2'b10, 2'b10, IDLE, SRC_1, 2'b10);
        // master 1 holds slave 0 under back-pressure
        add_aw(2'b10, 2'b10, 2'b00, 2'b00, SRC_1, IDLE, 2'b00);
        add_aw(2'b11, 2'b11, 2'b00, 2'b00, SRC_1, IDLE, 2'b00);
        add_aw(2'b11, 2'b11, 2'b00, 2'b01, SRC_1, IDLE, 2'b10);
        add_aw(2'b01, 2'b01, 2'b00, 2'b01, SRC_0, IDLE, 2'b01);
        // responses routed by tag
        add_b(2'b01, 2'b00, 2'b01, SRC_0, IDLE, 2'b01);
        add_b(2'b10, 2'b10, 2'b10, IDLE, SRC_1, 2'b10);
        add_b(2'b11, 2'b01, 2'b11, SRC_1, SRC_0, 2'b11);
        add_b(2'b11, 2'b00, 2'b01, SRC_0, IDLE, 2'b01);
        add_b(2'b10, 2'b00, 2'b00, SRC_1, IDLE, 2'b00);
        add_b(2'b11, 2'b00, 2'b00, SRC_1, IDLE, 2'b00);
        add_b(2'b11, 2'b00, 2'b01, SRC_1, IDLE, 2'b10);
        add_b(2'b01, 2'b00, 2'b01, SRC_0, IDLE, 2'b01);
        add_b(2'b11, 2'b11, 2'b10, IDLE, SRC_0, 2'b01);
        add_b(2'b10, 2'b11, 2'b10, IDLE, SRC_1, 2'b10);
        add_b(2'b00, 2'b00, 2'b11, IDLE, IDLE, 2'b00);
        table_built = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (entries[i]) begin
            @(negedge clk);
            drive_entry(entries[i], prev);
            #(PERIOD / 2 - 10);
            check_entry(entries[i]);
            prev = entries[i];
        end
        $display("%0d checks over %0d entries, %0d errors", checks, entries.size(), errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
design/xbar_pkg.sv
design/aw_req_if.sv
design/aw_request_decode.sv
design/aw_slave_arbiter.sv
design/b_response_router.sv
design/axi_xbar_2x2.sv
verif/tb_axi_xbar.sv

// ==== Bender.yml ====
package:
  name: axi_xbar_2x2

export_include_dirs:
  - include

sources:
  - files:
      - design/xbar_pkg.sv
      - design/aw_req_if.sv
      - design/aw_request_decode.sv
      - design/aw_slave_arbiter.sv
      - design/b_response_router.sv
      - design/axi_xbar_2x2.sv
  - target: test
    files:
      - verif/tb_axi_xbar.sv
